// File: files.f
rtl/drum_pkg.sv
rtl/midi_parser.sv
rtl/note_tracker.sv
rtl/frame_timer.sv
rtl/drum_visualizer.sv
tests/drum_visualizer_checker.sv
tests/drum_visualizer_tb.sv

// File: Bender.yml
package:
  name: drum_visualizer

sources:
  - rtl/drum_pkg.sv
  - rtl/midi_parser.sv
  - rtl/note_tracker.sv
  - rtl/frame_timer.sv
  - rtl/drum_visualizer.sv
  - target: test
    files:
      - tests/drum_visualizer_checker.sv
      - tests/drum_visualizer_tb.sv

// File: tests/drum_visualizer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module drum_visualizer_tb
  import drum_pkg::*;
();

  localparam int settle_cycles = 8;   // crossing bound when no change is visible
  localparam int level_timeout = 20;

  logic       clk;
  logic       clk_pixel;
  logic       rst;
  logic       byte_valid;
  midi_byte_t byte_data;
  midi_data_t inst_velocity [inst_count];
  logic       new_frame;

  midi_data_t exp_level [inst_count];  // model levels

  int   frame_gap = 0;  // pixel cycles since the last frame
  logic frame_seen = 1'b0;

  drum_visualizer i_dut (
    .clk           (clk),
    .clk_pixel     (clk_pixel),
    .rst           (rst),
    .byte_valid    (byte_valid),
    .byte_data     (byte_data),
    .inst_velocity (inst_velocity),
    .new_frame     (new_frame)
  );

  always #15 clk = ~clk;
  always #20 clk_pixel = ~clk_pixel;

  function automatic midi_data_t next_level(input midi_data_t level, input midi_data_t decay,
                                            input logic frame, input logic hit,
                                            input midi_data_t vel);
    if (frame) begin
      if (level > decay) return level - decay;
      return '0;
    end
    if (hit) return vel;
    return level;
  endfunction

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(input string name, input int got, input int expected);
    stop_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, expected));
  endtask

  task automatic check_levels();
    for (int i = 0; i < inst_count; i++) begin
      assert (inst_velocity[i] == exp_level[i])
        else value_error($sformatf("inst_velocity[%0d]", i), inst_velocity[i], exp_level[i]);
    end
  endtask

  task automatic apply_event(input midi_data_t key, input midi_data_t vel);
    for (int i = 0; i < inst_count; i++) begin
      exp_level[i] = next_level(exp_level[i], inst_decay[i], 1'b0, key == inst_keys[i], vel);
    end
  endtask

  task automatic wait_frame();
    int n;
    n = 0;
    do begin
      @(negedge clk_pixel);
      n++;
      if (n > 2 * frame_cycles) stop_run("timeout waiting for new_frame");
    end while (!new_frame);
  endtask

  task automatic wait_level(input int idx, input midi_data_t value);
    int n;
    n = 0;
    @(negedge clk_pixel);
    while (inst_velocity[idx] != value) begin
      if (n == level_timeout) begin
        stop_run($sformatf("timeout waiting for inst_velocity[%0d] to reach 0x%0h", idx, value));
      end
      @(negedge clk_pixel);
      n++;
    end
  endtask

  task automatic send_byte(input midi_byte_t value);
    @(negedge clk);
    byte_valid = 1'b1;
    byte_data  = value;
    @(negedge clk);
    byte_valid = 1'b0;
  endtask

  // data pair under the current running status, then wait for the crossing
  task automatic send_pair(input midi_data_t key, input midi_data_t vel);
    int   idx;
    logic change;
    idx = -1;
    for (int i = 0; i < inst_count; i++) begin
      if (key == inst_keys[i] && idx < 0) idx = i;
    end
    change = (idx >= 0) && (exp_level[idx] != vel);
    send_byte({1'b0, key});
    send_byte({1'b0, vel});
    apply_event(key, vel);
    if (change) begin
      wait_level(idx, vel);
    end else begin
      repeat (settle_cycles) @(negedge clk_pixel);
    end
    repeat (2) @(negedge clk_pixel);  // keeps the event spacing
    check_levels();
  endtask

  task automatic send_note(input logic [3:0] channel, input midi_data_t key,
                           input midi_data_t vel);
    send_byte({4'h9, channel});
    send_pair(key, vel);
  endtask

  // level check, frame period and model decay at every frame
  always @(negedge clk_pixel) begin
    frame_gap++;
    if (!rst && new_frame) begin
      if (frame_seen) begin
        assert (frame_gap == frame_cycles)
          else value_error("new_frame period", frame_gap, frame_cycles);
      end
      frame_seen = 1'b1;
      frame_gap  = 0;
      check_levels();
      for (int i = 0; i < inst_count; i++) begin
        exp_level[i] = next_level(exp_level[i], inst_decay[i], 1'b1, 1'b0, '0);
      end
    end
  end

  always @(negedge clk_pixel) begin
    if (i_dut.i_note_tracker.i_checker.fail_count != 0) begin
      stop_run("a bound assertion on the note tracker failed");
    end
  end

  initial begin
    int         cycles;
    int         pick;
    int         phase;
    logic [3:0] chan;
    midi_data_t key;
    midi_data_t vel;
    clk        = 1'b0;
    clk_pixel  = 1'b0;
    rst        = 1'b1;
    byte_valid = 1'b0;
    byte_data  = '0;
    for (int i = 0; i < inst_count; i++) exp_level[i] = '0;
    void'($urandom(32'h4b0e));

    repeat (5) @(negedge clk_pixel);
    rst = 1'b0;

    // reset state and first frame position
    check_levels();
    cycles = 0;
    do begin
      @(negedge clk_pixel);
      cycles++;
      if (cycles > 2 * frame_cycles) stop_run("timeout waiting for the first new_frame");
    end while (!new_frame);
    assert (cycles == frame_cycles)
      else value_error("new_frame position", cycles, frame_cycles);

    // one hit per instrument, plus an unmapped key
    wait_frame();
    for (int i = 0; i < inst_count; i++) begin
      send_note(4'h9, inst_keys[i], midi_data_t'(($urandom % 127) + 1));
    end
    send_note(4'h9, 7'd40, 7'd100);

    // decay, bass drum gone after one frame
    wait_frame();
    @(negedge clk_pixel);
    assert (inst_velocity[0] == '0)
      else value_error("inst_velocity[0]", inst_velocity[0], 0);
    check_levels();
    repeat (45) wait_frame();
    @(negedge clk_pixel);
    for (int i = 0; i < inst_count; i++) begin
      assert (inst_velocity[i] == '0)
        else value_error($sformatf("inst_velocity[%0d]", i), inst_velocity[i], 0);
    end

    // running status, last pair clears the snare
    wait_frame();
    send_byte(8'h99);
    send_pair(7'd36, midi_data_t'(($urandom % 127) + 1));
    send_pair(7'd38, midi_data_t'(($urandom % 127) + 1));
    send_pair(7'd46, midi_data_t'(($urandom % 127) + 1));
    send_pair(7'd38, 7'd0);

    // control change data is skipped
    wait_frame();
    send_byte(8'hb9);
    send_byte(8'd36);
    send_byte(8'd100);
    send_byte(8'd38);
    send_byte(8'd50);
    repeat (settle_cycles + 2) @(negedge clk_pixel);
    check_levels();
    send_note(4'h9, 7'd46, midi_data_t'(($urandom % 127) + 1));

    // random mix at random frame phases
    for (int n = 0; n < 40; n++) begin
      wait_frame();
      phase = $urandom % 40;
      repeat (phase) @(negedge clk_pixel);
      pick = $urandom % 5;
      if (pick < inst_count) key = inst_keys[pick];
      else if (pick == inst_count) key = 7'd40;
      else key = midi_data_t'($urandom);
      vel  = midi_data_t'($urandom);
      chan = 4'($urandom);
      send_note(chan, key, vel);
    end
    repeat (3) wait_frame();

    if (i_dut.i_note_tracker.i_checker.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_run("bound assertions reported failures");
    end
  end

endmodule

`default_nettype wire

// File: tests/drum_visualizer_checker.sv
`timescale 1ns/1ps
`default_nettype none

module drum_visualizer_checker
  import drum_pkg::*;
(
  input logic       clk_pixel,
  input logic       rst,
  input logic       new_frame,
  input logic       event_take,
  input midi_data_t inst_velocity [inst_count]
);

  int fail_count = 0;  // failed assertions so far

  // frame pulse is a single cycle
  assert property (@(posedge clk_pixel) disable iff (rst)
    new_frame |=> !new_frame)
    else begin
      $error("new_frame high for two cycles in a row");
      fail_count++;
    end

  for (genvar i = 0; i < inst_count; i++) begin : g_level
    // rising level needs a taken event
    assert property (@(posedge clk_pixel) disable iff (rst)
      (inst_velocity[i] > $past(inst_velocity[i])) |-> $past(event_take))
      else begin
        $error("inst_velocity[%0d] rose without an event", i);
        fail_count++;
      end

    assert property (@(posedge clk_pixel) disable iff (rst)
      new_frame |=> (inst_velocity[i] <= $past(inst_velocity[i])))
      else begin
        $error("inst_velocity[%0d] rose during decay", i);
        fail_count++;
      end

    // small level saturates instead of wrapping
    assert property (@(posedge clk_pixel) disable iff (rst)
      (new_frame && (inst_velocity[i] <= inst_decay[i])) |=> (inst_velocity[i] == '0))
      else begin
        $error("inst_velocity[%0d] wrapped during decay", i);
        fail_count++;
      end
  end

endmodule

bind note_tracker drum_visualizer_checker i_checker (
  .clk_pixel     (clk_pixel),
  .rst           (rst),
  .new_frame     (new_frame),
  .event_take    (event_take),
  .inst_velocity (inst_velocity)
);

`default_nettype wire

// File: rtl/drum_visualizer.sv
`timescale 1ns/1ps
`default_nettype none

module drum_visualizer
  import drum_pkg::*;
(
  input  logic       clk,
  input  logic       clk_pixel,
  input  logic       rst,

  // MIDI side, on clk
  input  logic       byte_valid,
  input  midi_byte_t byte_data,

  // video side, on clk_pixel
  output midi_data_t inst_velocity [inst_count],
  output logic       new_frame
);

  // parser to tracker, clk domain
  logic       note_valid;
  midi_data_t note;
  midi_data_t velocity;

  midi_parser i_midi_parser (
    .clk        (clk),
    .rst        (rst),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .note_valid (note_valid),
    .note       (note),
    .velocity   (velocity)
  );

  note_tracker i_note_tracker (
    .clk           (clk),
    .clk_pixel     (clk_pixel),
    .rst           (rst),
    .note_valid    (note_valid),
    .note          (note),
    .velocity      (velocity),
    .new_frame     (new_frame),
    .inst_velocity (inst_velocity)
  );

  frame_timer i_frame_timer (
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .new_frame (new_frame)
  );

endmodule

`default_nettype wire

// File: rtl/frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_timer
  import drum_pkg::*;
(
  input  logic clk_pixel,
  input  logic rst,
  output logic new_frame
);

  frame_count_t count;
  logic         terminal;

  // last cycle of the frame
  assign terminal = (count == frame_count_t'(frame_cycles - 1));

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      count     <= '0;
      new_frame <= 1'b0;
    end else begin
      new_frame <= terminal;  // first pulse frame_cycles edges after reset
      if (terminal) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/note_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module note_tracker
  import drum_pkg::*;
(
  input  logic       clk,
  input  logic       clk_pixel,
  input  logic       rst,

  // clk domain
  input  logic       note_valid,
  input  midi_data_t note,
  input  midi_data_t velocity,

  // clk_pixel domain
  input  logic       new_frame,
  output midi_data_t inst_velocity [inst_count]
);

  // clk side capture
  logic       toggle_clk;  // flips once per event
  midi_data_t note_clk;
  midi_data_t velocity_clk;

  // clk_pixel side, three stages each
  logic [2:0] toggle_sync;
  midi_data_t note_sync [3];
  midi_data_t velocity_sync [3];

  logic toggle_seen;  // last consumed toggle
  logic event_pending;
  logic event_take;

  always_ff @(posedge clk) begin
    if (rst) begin
      toggle_clk   <= 1'b0;
      note_clk     <= '0;
      velocity_clk <= '0;
    end else if (note_valid) begin
      toggle_clk   <= ~toggle_clk;
      note_clk     <= note;
      velocity_clk <= velocity;
    end
  end

  // payload stages, flushed by the reset length
  always_ff @(posedge clk_pixel) begin
    note_sync[0]     <= note_clk;
    note_sync[1]     <= note_sync[0];
    note_sync[2]     <= note_sync[1];
    velocity_sync[0] <= velocity_clk;
    velocity_sync[1] <= velocity_sync[0];
    velocity_sync[2] <= velocity_sync[1];
  end

  // new toggle seen and payload settled over the last two stages
  assign event_pending = (toggle_sync[2] != toggle_seen) &&
                         (note_sync[2] == note_sync[1]) &&
                         (velocity_sync[2] == velocity_sync[1]);

  // decay has priority, event waits one cycle
  assign event_take = event_pending && !new_frame;

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      toggle_sync <= '0;
      toggle_seen <= 1'b0;
      for (int i = 0; i < inst_count; i++) begin
        inst_velocity[i] <= '0;
      end
    end else begin
      toggle_sync <= {toggle_sync[1:0], toggle_clk};
      if (new_frame) begin
        for (int i = 0; i < inst_count; i++) begin
          // saturate at zero
          inst_velocity[i] <= (inst_velocity[i] > inst_decay[i]) ?
                              inst_velocity[i] - inst_decay[i] : '0;
        end
      end else if (event_take) begin
        toggle_seen <= toggle_sync[2];
        for (int i = 0; i < inst_count; i++) begin
          if (note_sync[2] == inst_keys[i]) begin
            inst_velocity[i] <= velocity_sync[2];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/midi_parser.sv
`timescale 1ns/1ps
`default_nettype none

module midi_parser
  import drum_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       byte_valid,
  input  midi_byte_t byte_data,
  output logic       note_valid,
  output midi_data_t note,
  output midi_data_t velocity
);

  parser_state_t state;
  logic          running_note_on;  // running status is note-on
  midi_data_t    note_hold;        // first data byte of the pair

  logic is_status;
  logic is_note_on;

  assign is_status  = byte_data[7];
  assign is_note_on = (byte_data[7:4] == 4'h9);

  // control part of the decoder
  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= wait_status;
      running_note_on <= 1'b0;
      note_valid      <= 1'b0;
    end else begin
      note_valid <= 1'b0;  // strobe, one cycle only
      if (byte_valid) begin
        if (is_status) begin
          // any status byte restarts the parse
          running_note_on <= is_note_on;
          state           <= is_note_on ? wait_note : wait_status;
        end else begin
          case (state)
            wait_status: begin
              // data under an ignored status is dropped
              if (running_note_on) begin
                state <= wait_velocity;
              end
            end
            wait_note: begin
              state <= wait_velocity;
            end
            wait_velocity: begin
              note_valid <= 1'b1;
              state      <= wait_note;  // running status, next pair follows
            end
            default: begin
              state <= wait_status;
            end
          endcase
        end
      end
    end
  end

  // payload, no reset needed
  always_ff @(posedge clk) begin
    if (byte_valid && !is_status) begin
      case (state)
        wait_status: begin
          if (running_note_on) begin
            note_hold <= byte_data[6:0];
          end
        end
        wait_note: begin
          note_hold <= byte_data[6:0];
        end
        wait_velocity: begin
          note     <= note_hold;
          velocity <= byte_data[6:0];  // zero passes through, clears the level
        end
        default: begin
          note_hold <= note_hold;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/drum_pkg.sv
`default_nettype none

package drum_pkg;

  // raw byte off the MIDI stream
  typedef logic [7:0] midi_byte_t;

  // 7-bit data value, note number or velocity
  typedef logic [6:0] midi_data_t;

  // tracked drum instruments
  localparam int inst_count = 3;

  // GM drum keys per instrument slot
  localparam midi_data_t inst_keys [inst_count] = '{
    7'd36,  // bass drum
    7'd38,  // snare
    7'd46   // open hi-hat
  };

  // level drop per frame, bass drum gone in one frame
  localparam midi_data_t inst_decay [inst_count] = '{
    7'd127,
    7'd16,
    7'd3
  };

  // short frame for simulation, raise for a real video mode
  localparam int frame_cycles = 64;
  localparam int frame_cnt_w = $clog2(frame_cycles);

  typedef logic [frame_cnt_w-1:0] frame_count_t;

  typedef enum logic [1:0] {
    wait_status,
    wait_note,
    wait_velocity
  } parser_state_t;

endpackage

`default_nettype wire
